// File: Bender.yml
package:
  name: pst_vreg

sources:
  - files:
      - source/pst_pkg.sv
      - source/pst_create_dec.sv
      - source/pst_free_alloc.sv
      - source/pst_vreg_entry.sv
      - source/pst_status_merge.sv
      - source/pst_vreg_top.sv
  - target: test
    files:
      - verif/pst_vreg_tb.sv

// File: source/pst_create_dec.sv
//==================================================
// Create request decoder
// Turns dispatch slots into one-hot per-entry
// create requests
//==================================================

`timescale 1ns/10ps

module pst_create_dec
  import pst_pkg::*;
#(
  parameter int NUM_ENTRY = 16
) (
  input  dis_slot_t                           dis [DIS_WIDTH],
  output logic [NUM_ENTRY-1:0][DIS_WIDTH-1:0] create_vld
);

  // Entry i is hit by slot k when the slot names it
  always_comb begin
    for (int i = 0; i < NUM_ENTRY; i++) begin
      for (int k = 0; k < DIS_WIDTH; k++) begin
        create_vld[i][k] = dis[k].vld && (dis[k].preg == preg_t'(i));
      end
    end
  end

endmodule

// File: source/pst_free_alloc.sv
//==================================================
// Free register allocator
// Moves one free entry per cycle into the pool
// waiting for allocation
//==================================================

`timescale 1ns/10ps

module pst_free_alloc
  import pst_pkg::*;
#(
  parameter int NUM_ENTRY = 16
) (
  input  logic                 sm_clk,
  input  logic                 cpurst_b,
  input  logic                 flush,
  input  logic [NUM_ENTRY-1:0] dealloc_st,
  input  logic [NUM_ENTRY-1:0] alloc_ready,
  output logic [NUM_ENTRY-1:0] dealloc_vld
);

  localparam int CNT_W = $clog2(NUM_ENTRY + 1);

  logic [CNT_W-1:0]     wf_cnt;
  logic [NUM_ENTRY-1:0] pick;
  logic [NUM_ENTRY-1:0] prev_pick;
  logic                 found;

  // Entries already waiting for allocation
  always_comb begin
    wf_cnt = '0;
    for (int i = 0; i < NUM_ENTRY; i++) begin
      wf_cnt = wf_cnt + CNT_W'(alloc_ready[i]);
    end
  end

  // Lowest free entry, skipping last cycle's pick
  always_comb begin
    pick  = '0;
    found = 1'b0;
    for (int i = 0; i < NUM_ENTRY; i++) begin
      if (!found && dealloc_st[i] && !prev_pick[i]) begin
        pick[i] = 1'b1;
        found   = 1'b1;
      end
    end
  end

  assign dealloc_vld = ((wf_cnt < DIS_WIDTH) && !flush) ? pick : '0;

  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      prev_pick <= '0;
    end else begin
      prev_pick <= dealloc_vld;
    end
  end

endmodule

// File: source/pst_pkg.sv
//==================================================
// Vector register status table shared types
// Widths, dispatch and retire slot layouts and the
// lifecycle and writeback state encodings
//==================================================

package pst_pkg;

  // Pipeline widths
  localparam int DIS_WIDTH = 4;
  localparam int RET_WIDTH = 3;

  // Register file sizes
  localparam int AREG_NUM  = 32;
  localparam int PREG_MAX  = 64;

  typedef logic [6:0]                  iid_t;
  typedef logic [$clog2(AREG_NUM)-1:0] areg_t;
  typedef logic [$clog2(PREG_MAX)-1:0] preg_t;

  // One dispatch slot, 25 bits
  typedef struct packed {
    logic  vld;
    preg_t preg;
    iid_t  iid;
    areg_t dstv_reg;
    preg_t rel_vreg;
  } dis_slot_t;

  // One retire slot, id compare one cycle ahead of the strobe
  typedef struct packed {
    logic pre_vld;
    iid_t pre_iid;
    logic vld;
  } ret_slot_t;

  //==================================================
  // State encodings
  //==================================================
  typedef enum logic [4:0] {
    DEALLOC  = 5'b00001,
    WF_ALLOC = 5'b00010,
    ALLOC    = 5'b00100,
    RETIRE   = 5'b01000,
    RELEASE  = 5'b10000
  } life_state_e;

  typedef enum logic {
    IDLE = 1'b0,
    WB   = 1'b1
  } wb_state_e;

endpackage

// File: source/pst_status_merge.sv
//==================================================
// Status merge
// Folds per-entry release and recovery requests
// into table-wide one-hot vectors
//==================================================

`timescale 1ns/10ps

module pst_status_merge
  import pst_pkg::*;
#(
  parameter int NUM_ENTRY = 16
) (
  input  logic [NUM_ENTRY-1:0] rel_req,
  input  logic [NUM_ENTRY-1:0] dreg_req,
  input  preg_t                rel_vreg [NUM_ENTRY],
  input  areg_t                dstv_reg [NUM_ENTRY],
  output logic [NUM_ENTRY-1:0] release_vec,
  output logic [AREG_NUM-1:0]  recovery_vec
);

  logic [PREG_MAX-1:0] rel_onehot;

  // Released physical registers
  always_comb begin
    rel_onehot = '0;
    for (int i = 0; i < NUM_ENTRY; i++) begin
      if (rel_req[i]) begin
        rel_onehot = rel_onehot | (PREG_MAX'(1) << rel_vreg[i]);
      end
    end
  end

  assign release_vec = rel_onehot[NUM_ENTRY-1:0];

  // Architectural destinations held by retired producers
  always_comb begin
    recovery_vec = '0;
    for (int i = 0; i < NUM_ENTRY; i++) begin
      if (dreg_req[i]) begin
        recovery_vec = recovery_vec | (AREG_NUM'(1) << dstv_reg[i]);
      end
    end
  end

endmodule

// File: source/pst_vreg_entry.sv
//==================================================
// Physical vector register status entry
// Lifecycle and writeback FSMs, producer info and
// early retire id match for one register
//==================================================

`timescale 1ns/10ps

module pst_vreg_entry
  import pst_pkg::*;
(
  input  logic                 sm_clk,
  input  logic                 cpurst_b,
  input  logic                 flush,
  input  logic                 async_flush,
  input  logic                 dealloc_vld,
  input  logic                 release_vld,
  input  logic                 wb_vld,
  input  logic [DIS_WIDTH-1:0] create_vld,
  input  dis_slot_t            dis [DIS_WIDTH],
  input  ret_slot_t            ret [RET_WIDTH],
  output logic                 state_dealloc,
  output logic                 state_wf_alloc,
  output logic                 state_alloc_release,
  output logic                 rel_req,
  output logic                 dreg_req,
  output preg_t                rel_vreg,
  output areg_t                dstv_reg
);

  life_state_e          life_cur;
  life_state_e          life_next;
  wb_state_e            wb_cur;
  wb_state_e            wb_next;
  logic                 create;
  logic                 is_wb;
  logic                 retire_vld;
  logic [RET_WIDTH-1:0] iid_match;
  iid_t                 iid;
  iid_t                 create_iid;
  areg_t                create_dstv_reg;
  preg_t                create_rel_vreg;

  assign create = |create_vld;
  assign is_wb  = (wb_cur == WB);

  //==================================================
  // Lifecycle FSM
  //==================================================
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      life_cur <= DEALLOC;
    end else begin
      life_cur <= life_next;
    end
  end

  always_comb begin
    life_next = life_cur;
    case (life_cur)
      DEALLOC:  if (dealloc_vld && !flush) life_next = WF_ALLOC;
      WF_ALLOC: begin
        if (flush)       life_next = DEALLOC;
        else if (create) life_next = ALLOC;
      end
      ALLOC: begin
        if (flush)                     life_next = DEALLOC;
        else if (release_vld && is_wb) life_next = DEALLOC;
        else if (release_vld)          life_next = RELEASE;
        else if (retire_vld)           life_next = RETIRE;
      end
      RETIRE: begin
        if (release_vld && is_wb) life_next = DEALLOC;
        else if (release_vld)     life_next = RELEASE;
      end
      RELEASE:  if (is_wb) life_next = DEALLOC;
      default:  life_next = DEALLOC;
    endcase
  end

  assign state_dealloc       = (life_cur == DEALLOC);
  assign state_wf_alloc      = (life_cur == WF_ALLOC);
  assign state_alloc_release = (life_cur == ALLOC) || (life_cur == RELEASE);

  //==================================================
  // Writeback FSM
  //==================================================
  always_comb begin
    wb_next = wb_cur;
    case (wb_cur)
      IDLE:    if (wb_vld) wb_next = WB;
      WB:      if (state_dealloc) wb_next = IDLE;
      default: wb_next = IDLE;
    endcase
  end

  // Async flush wins over a create in the same cycle
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      wb_cur <= IDLE;
    end else if (async_flush) begin
      wb_cur <= WB;
    end else if (create) begin
      wb_cur <= IDLE;
    end else begin
      wb_cur <= wb_next;
    end
  end

  //==================================================
  // Producer information
  //==================================================
  // create_vld is one-hot, so OR-ing the masked slots selects one
  always_comb begin
    create_iid      = '0;
    create_dstv_reg = '0;
    create_rel_vreg = '0;
    for (int k = 0; k < DIS_WIDTH; k++) begin
      if (create_vld[k]) begin
        create_iid      = create_iid | dis[k].iid;
        create_dstv_reg = create_dstv_reg | dis[k].dstv_reg;
        create_rel_vreg = create_rel_vreg | dis[k].rel_vreg;
      end
    end
  end

  always_ff @(posedge sm_clk) begin
    if (create) begin
      iid      <= create_iid;
      dstv_reg <= create_dstv_reg;
      rel_vreg <= create_rel_vreg;
    end
  end

  // Id compare one cycle before the retire strobe
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      iid_match <= '0;
    end else begin
      for (int j = 0; j < RET_WIDTH; j++) begin
        if (ret[j].pre_vld) begin
          iid_match[j] <= (life_cur == ALLOC) && (iid == ret[j].pre_iid);
        end
      end
    end
  end

  always_comb begin
    retire_vld = 1'b0;
    for (int j = 0; j < RET_WIDTH; j++) begin
      retire_vld = retire_vld | (ret[j].vld && iid_match[j]);
    end
  end

  // Release of the previous mapping and recovery request
  assign rel_req  = (life_cur == ALLOC) && retire_vld;
  assign dreg_req = (life_cur == RETIRE);

endmodule

// File: source/pst_vreg_top.sv
//==================================================
// Physical vector register status table
// Create decode, free allocation, per-register
// entries and release/recovery merge
//==================================================

`timescale 1ns/10ps

module pst_vreg_top
  import pst_pkg::*;
#(
  parameter int NUM_ENTRY = 16
) (
  input  logic                 sm_clk,
  input  logic                 cpurst_b,
  input  dis_slot_t            dis [DIS_WIDTH],
  input  ret_slot_t            ret [RET_WIDTH],
  input  logic [NUM_ENTRY-1:0] wb_vld,
  input  logic                 flush,
  input  logic                 async_flush,
  output logic [NUM_ENTRY-1:0] dealloc_st,
  output logic [NUM_ENTRY-1:0] alloc_ready,
  output logic [NUM_ENTRY-1:0] alloc_release_st,
  output logic [NUM_ENTRY-1:0] release_vec,
  output logic [AREG_NUM-1:0]  recovery_vec
);

  logic [NUM_ENTRY-1:0][DIS_WIDTH-1:0] create_vld;
  logic [NUM_ENTRY-1:0]                dealloc_vld;
  logic [NUM_ENTRY-1:0]                rel_req;
  logic [NUM_ENTRY-1:0]                dreg_req;
  preg_t                               rel_vreg [NUM_ENTRY];
  areg_t                               dstv_reg [NUM_ENTRY];

  pst_create_dec #(.NUM_ENTRY(NUM_ENTRY)) i_create_dec (
    .dis        (dis),
    .create_vld (create_vld)
  );

  pst_free_alloc #(.NUM_ENTRY(NUM_ENTRY)) i_free_alloc (
    .sm_clk      (sm_clk),
    .cpurst_b    (cpurst_b),
    .flush       (flush),
    .dealloc_st  (dealloc_st),
    .alloc_ready (alloc_ready),
    .dealloc_vld (dealloc_vld)
  );

  // One entry per physical register, release fed back by index
  for (genvar i = 0; i < NUM_ENTRY; i++) begin : g_entry
    pst_vreg_entry i_entry (
      .sm_clk              (sm_clk),
      .cpurst_b            (cpurst_b),
      .flush               (flush),
      .async_flush         (async_flush),
      .dealloc_vld         (dealloc_vld[i]),
      .release_vld         (release_vec[i]),
      .wb_vld              (wb_vld[i]),
      .create_vld          (create_vld[i]),
      .dis                 (dis),
      .ret                 (ret),
      .state_dealloc       (dealloc_st[i]),
      .state_wf_alloc      (alloc_ready[i]),
      .state_alloc_release (alloc_release_st[i]),
      .rel_req             (rel_req[i]),
      .dreg_req            (dreg_req[i]),
      .rel_vreg            (rel_vreg[i]),
      .dstv_reg            (dstv_reg[i])
    );
  end

  pst_status_merge #(.NUM_ENTRY(NUM_ENTRY)) i_status_merge (
    .rel_req      (rel_req),
    .dreg_req     (dreg_req),
    .rel_vreg     (rel_vreg),
    .dstv_reg     (dstv_reg),
    .release_vec  (release_vec),
    .recovery_vec (recovery_vec)
  );

endmodule

// File: verif/pst_vreg_tb.sv
//==================================================
// Status table testbench
// Random dispatch, retire, writeback and flush
// traffic checked against a cycle model
//==================================================

`timescale 1ns/10ps

module pst_vreg_tb
  import pst_pkg::*;
();

  localparam int NUM_ENTRY = 16;
  localparam int P1_END    = DIS_WIDTH + 2;
  localparam int P2_END    = 1000;
  localparam int RUN_CYC   = 2000;
  localparam int TIMEOUT   = RUN_CYC + RUN_CYC / 10;

  logic                 sm_clk;
  logic                 cpurst_b;
  dis_slot_t            dis [DIS_WIDTH];
  ret_slot_t            ret [RET_WIDTH];
  logic [NUM_ENTRY-1:0] wb_vld;
  logic                 flush;
  logic                 async_flush;
  logic [NUM_ENTRY-1:0] dealloc_st;
  logic [NUM_ENTRY-1:0] alloc_ready;
  logic [NUM_ENTRY-1:0] alloc_release_st;
  logic [NUM_ENTRY-1:0] release_vec;
  logic [AREG_NUM-1:0]  recovery_vec;

  // Reference model
  life_state_e          m_life [NUM_ENTRY];
  wb_state_e            m_wb [NUM_ENTRY];
  iid_t                 m_iid [NUM_ENTRY];
  areg_t                m_dst [NUM_ENTRY];
  preg_t                m_rel [NUM_ENTRY];
  logic [RET_WIDTH-1:0] m_match [NUM_ENTRY];
  logic [NUM_ENTRY-1:0] m_prev_pick;
  logic [NUM_ENTRY-1:0] m_af;

  int cyc;
  int tmo_cyc;
  int chk_cnt;
  int err_cnt;
  int tst_chk0;
  int tst_err0;
  int tst_cnt;
  int tst_fail;
  int ev_to_rel;
  int ev_retire;
  int ev_wb_free;
  int ev_flush;
  int ev_async;

  pst_vreg_top #(.NUM_ENTRY(NUM_ENTRY)) i_dut (
    .sm_clk           (sm_clk),
    .cpurst_b         (cpurst_b),
    .dis              (dis),
    .ret              (ret),
    .wb_vld           (wb_vld),
    .flush            (flush),
    .async_flush      (async_flush),
    .dealloc_st       (dealloc_st),
    .alloc_ready      (alloc_ready),
    .alloc_release_st (alloc_release_st),
    .release_vec      (release_vec),
    .recovery_vec     (recovery_vec)
  );

  always #2 sm_clk = ~sm_clk;

  always @(posedge sm_clk) begin
    tmo_cyc++;
    if (tmo_cyc >= TIMEOUT) begin
      $display("error: run did not finish within %0d cycles", TIMEOUT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [PREG_MAX-1:0] exp,
                           input logic [PREG_MAX-1:0] got);
    chk_cnt++;
    assert (got === exp) else begin
      $display("mismatch %s: expected %h, got %h", name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic expect_seen(input string what, input int n);
    chk_cnt++;
    assert (n > 0) else begin
      $display("error: no %s seen during the run", what);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = err_cnt - tst_err0;
    tst_cnt++;
    if (errs != 0)
      tst_fail++;
    $display("test %0d %s: %0d checks, %0d errors", tst_cnt, name, chk_cnt - tst_chk0, errs);
    tst_chk0 = chk_cnt;
    tst_err0 = err_cnt;
  endtask

  // Early id match seen by this cycle's retire strobes
  function automatic logic retire_hit(input int i);
    logic hit;
    hit = 1'b0;
    for (int j = 0; j < RET_WIDTH; j++) begin
      hit = hit | (ret[j].vld & m_match[i][j]);
    end
    return hit;
  endfunction

  function automatic logic [NUM_ENTRY-1:0] model_release();
    logic [NUM_ENTRY-1:0] vec;
    vec = '0;
    for (int i = 0; i < NUM_ENTRY; i++) begin
      if (m_life[i] == ALLOC && retire_hit(i))
        vec[m_rel[i]] = 1'b1;
    end
    return vec;
  endfunction

  function automatic logic [AREG_NUM-1:0] model_recovery();
    logic [AREG_NUM-1:0] vec;
    vec = '0;
    for (int i = 0; i < NUM_ENTRY; i++) begin
      if (m_life[i] == RETIRE)
        vec[m_dst[i]] = 1'b1;
    end
    return vec;
  endfunction

  //==================================================
  // Model update at the rising edge
  //==================================================
  task automatic model_step();
    logic [NUM_ENTRY-1:0] rel;
    logic [NUM_ENTRY-1:0] pick;
    logic                 cr;
    logic                 hit;
    int                   ci;
    int                   wf;
    life_state_e          nl;
    wb_state_e            nw;
    rel  = model_release();
    pick = '0;
    wf   = 0;
    for (int i = 0; i < NUM_ENTRY; i++) begin
      wf += (m_life[i] == WF_ALLOC);
    end
    // One free entry per cycle, never the one picked last cycle
    if (wf < DIS_WIDTH && !flush) begin
      for (int i = 0; i < NUM_ENTRY; i++) begin
        if (pick == '0 && m_life[i] == DEALLOC && !m_prev_pick[i])
          pick[i] = 1'b1;
      end
    end
    m_prev_pick = pick;
    for (int i = 0; i < NUM_ENTRY; i++) begin
      cr = 1'b0;
      ci = 0;
      for (int k = 0; k < DIS_WIDTH; k++) begin
        if (dis[k].vld && dis[k].preg == preg_t'(i)) begin
          cr = 1'b1;
          ci = k;
        end
      end
      hit = retire_hit(i);
      for (int j = 0; j < RET_WIDTH; j++) begin
        if (ret[j].pre_vld)
          m_match[i][j] = (m_life[i] == ALLOC) && (m_iid[i] == ret[j].pre_iid);
      end
      nl = m_life[i];
      case (m_life[i])
        DEALLOC: if (pick[i] && !flush) nl = WF_ALLOC;
        WF_ALLOC: begin
          if (flush)
            nl = DEALLOC;
          else if (cr)
            nl = ALLOC;
        end
        ALLOC, RETIRE: begin
          if (m_life[i] == ALLOC && flush)
            nl = DEALLOC;
          else if (rel[i])
            nl = (m_wb[i] == WB) ? DEALLOC : RELEASE;
          else if (m_life[i] == ALLOC && hit)
            nl = RETIRE;
        end
        RELEASE: if (m_wb[i] == WB) nl = DEALLOC;
        default: nl = m_life[i];
      endcase
      nw = m_wb[i];
      if (async_flush)
        nw = WB;
      else if (cr)
        nw = IDLE;
      else if (m_wb[i] == IDLE && wb_vld[i])
        nw = WB;
      else if (m_wb[i] == WB && m_life[i] == DEALLOC)
        nw = IDLE;
      // Event counts for the coverage checks
      ev_to_rel  += (m_life[i] != RELEASE && nl == RELEASE);
      ev_retire  += (m_life[i] == ALLOC && nl == RETIRE);
      ev_wb_free += (m_life[i] == RELEASE && nl == DEALLOC && !m_af[i]);
      ev_flush   += (flush && m_life[i] inside {WF_ALLOC, ALLOC});
      ev_async   += (!flush && rel[i] && m_af[i] && m_life[i] inside {ALLOC, RETIRE} &&
                     nl == DEALLOC);
      m_af[i] = (async_flush || m_af[i]) && (nw == WB);
      if (cr) begin
        m_iid[i] = dis[ci].iid;
        m_dst[i] = dis[ci].dstv_reg;
        m_rel[i] = dis[ci].rel_vreg;
      end
      m_life[i] = nl;
      m_wb[i]   = nw;
    end
  endtask

  //==================================================
  // Stimulus for the coming cycle
  //==================================================
  task automatic drive_stim(input bit active, input bit flushes);
    dis_slot_t            nd [DIS_WIDTH];
    logic [NUM_ENTRY-1:0] nwb;
    int                   alloc_q [$];
    int                   busy_q [$];
    int                   slot;
    for (int i = 0; i < NUM_ENTRY; i++) begin
      if (m_life[i] == ALLOC)
        alloc_q.push_back(i);
      if (m_life[i] inside {ALLOC, RETIRE})
        busy_q.push_back(i);
      nwb[i] = active && ($urandom_range(7) == 0);
    end
    slot = 0;
    for (int k = 0; k < DIS_WIDTH; k++) begin
      nd[k] = '0;
    end
    for (int i = 0; i < NUM_ENTRY; i++) begin
      if (active && m_life[i] == WF_ALLOC && slot < DIS_WIDTH && $urandom_range(1) == 1) begin
        nd[slot].vld      = 1'b1;
        nd[slot].preg     = preg_t'(i);
        nd[slot].iid      = iid_t'($urandom);
        nd[slot].dstv_reg = areg_t'($urandom);
        if (busy_q.size() > 0)
          nd[slot].rel_vreg = preg_t'(busy_q[$urandom_range(busy_q.size() - 1)]);
        slot++;
      end
    end
    for (int k = 0; k < DIS_WIDTH; k++) begin
      dis[k] <= nd[k];
    end
    // Retire strobe follows its id compare by one cycle
    for (int j = 0; j < RET_WIDTH; j++) begin
      ret[j].vld     <= ret[j].pre_vld;
      ret[j].pre_vld <= active && alloc_q.size() > 0 && ($urandom_range(2) == 0);
      ret[j].pre_iid <= (alloc_q.size() > 0) ?
                        m_iid[alloc_q[$urandom_range(alloc_q.size() - 1)]] : '0;
    end
    wb_vld      <= nwb;
    flush       <= flushes && ($urandom_range(49) == 0);
    async_flush <= flushes && ($urandom_range(79) == 0);
  endtask

  task automatic compare_all();
    logic [NUM_ENTRY-1:0] e_dealloc;
    logic [NUM_ENTRY-1:0] e_ready;
    logic [NUM_ENTRY-1:0] e_alloc_rel;
    for (int i = 0; i < NUM_ENTRY; i++) begin
      e_dealloc[i]   = (m_life[i] == DEALLOC);
      e_ready[i]     = (m_life[i] == WF_ALLOC);
      e_alloc_rel[i] = (m_life[i] == ALLOC) || (m_life[i] == RELEASE);
    end
    check_val("dealloc_st", e_dealloc, dealloc_st);
    check_val("alloc_ready", e_ready, alloc_ready);
    check_val("alloc_release_st", e_alloc_rel, alloc_release_st);
    check_val("release_vec", model_release(), release_vec);
    check_val("recovery_vec", model_recovery(), recovery_vec);
  endtask

  initial begin
    sm_clk      = 1'b0;
    cpurst_b    = 1'b0;
    wb_vld      = '0;
    flush       = 1'b0;
    async_flush = 1'b0;
    for (int k = 0; k < DIS_WIDTH; k++) begin
      dis[k] = '0;
    end
    for (int j = 0; j < RET_WIDTH; j++) begin
      ret[j] = '0;
    end
    for (int i = 0; i < NUM_ENTRY; i++) begin
      m_life[i]  = DEALLOC;
      m_wb[i]    = IDLE;
      m_iid[i]   = '0;
      m_dst[i]   = '0;
      m_rel[i]   = '0;
      m_match[i] = '0;
    end
    m_prev_pick = '0;
    m_af        = '0;
    void'($urandom(8));
    repeat (3) @(posedge sm_clk);
    cpurst_b <= 1'b1;
    @(negedge sm_clk);
    check_val("dealloc_st", {NUM_ENTRY{1'b1}}, dealloc_st);
    check_val("alloc_ready", '0, alloc_ready);
    compare_all();
    for (cyc = 1; cyc <= RUN_CYC; cyc++) begin
      @(posedge sm_clk);
      model_step();
      drive_stim(cyc > P1_END, cyc > P2_END);
      @(negedge sm_clk);
      compare_all();
      // Lowest free entries fill the pool one per edge
      if (cyc <= DIS_WIDTH)
        check_val("alloc_ready", PREG_MAX'((1 << cyc) - 1), alloc_ready);
      if (cyc == P1_END)
        end_test("reset and free allocation");
      if (cyc == P2_END) begin
        expect_seen("producer retire", ev_retire);
        expect_seen("release into RELEASE", ev_to_rel);
        expect_seen("writeback of a released entry", ev_wb_free);
        end_test("create, retire, release and writeback");
      end
    end
    expect_seen("flush of a live entry", ev_flush);
    expect_seen("release after async flush", ev_async);
    end_test("flush, async flush and recovery");
    $display("%0d tests, %0d failed, %0d checks, %0d errors", tst_cnt, tst_fail, chk_cnt,
             err_cnt);
    if (err_cnt == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: vlog.f
source/pst_pkg.sv
source/pst_create_dec.sv
source/pst_free_alloc.sv
source/pst_vreg_entry.sv
source/pst_status_merge.sv
source/pst_vreg_top.sv
verif/pst_vreg_tb.sv
